// File: hw/camera_pkg.sv
package camera_pkg;

    // Raw sensor sample and debayered channel
    typedef logic [9:0] raw_pixel_t;
    typedef logic [9:0] colour_t;

    // Command port and buffer words
    typedef logic [7:0] byte_t;
    typedef logic [15:0] buffer_addr_t;
    typedef logic [7:0] operand_count_t;

    // Raw frame geometry
    localparam int SENSOR_WIDTH = 24;
    localparam int SENSOR_HEIGHT = 24;

    // Counters run one past the last column and row at the end of a line
    localparam int COORD_BITS =
        $clog2((SENSOR_WIDTH > SENSOR_HEIGHT ? SENSOR_WIDTH : SENSOR_HEIGHT) + 1);
    typedef logic [COORD_BITS-1:0] coord_t;

    // Crop window in debayered coordinates with exclusive ends
    localparam coord_t CROP_X_START = 4;
    localparam coord_t CROP_X_END = 20;
    localparam coord_t CROP_Y_START = 4;
    localparam coord_t CROP_Y_END = 20;

    // Bytes in one captured frame, one per cropped pixel
    localparam int CAPTURE_SIZE = 256;

    // Metering window of 16 by 16 pixels
    localparam coord_t METER_X_START = 2;
    localparam coord_t METER_X_END = 18;
    localparam coord_t METER_Y_START = 2;
    localparam coord_t METER_Y_END = 18;

    // log2 of the metering pixel count
    localparam int METER_SHIFT = 8;

    // Host command op codes
    localparam byte_t OP_CAPTURE = 8'h20;
    localparam byte_t OP_BYTES_AVAILABLE = 8'h21;
    localparam byte_t OP_READ_DATA = 8'h22;
    localparam byte_t OP_METERING = 8'h25;

    typedef enum logic [1:0] {
        IDLE,
        ARMED,
        CAPTURING
    } capture_state_t;

endpackage

// File: hw/pixel_if.sv
`timescale 1ns/1ps

interface pixel_if import camera_pkg::*; ();

    colour_t red;
    colour_t green;
    colour_t blue;
    logic line_valid;
    logic frame_valid;

    modport source (
        output red, green, blue, line_valid, frame_valid
    );

    modport sink (
        input red, green, blue, line_valid, frame_valid
    );

endinterface

// File: hw/debayer.sv
`timescale 1ns/1ps

module debayer import camera_pkg::*; (
    input logic clock_spi_in,
    input logic mipi_byte_reset_n,
    input raw_pixel_t bayer_data_i,
    input logic line_valid_i,
    input logic frame_valid_i,
    pixel_if.source pixel_o
);

    // Previous raw line, indexed by column
    raw_pixel_t line_buffer [SENSOR_WIDTH];

    raw_pixel_t prev_pixel;
    raw_pixel_t above_prev;
    raw_pixel_t above_cur;
    coord_t x_count;
    coord_t y_count;
    logic line_valid_q;

    colour_t red;
    colour_t blue;
    logic [$bits(raw_pixel_t):0] green_sum;

    // Place the 2x2 block ending at the current sample on the RGGB grid
    always_comb begin
        above_cur = line_buffer[x_count];
        case ({y_count[0], x_count[0]})
            2'b11: begin
                red = above_prev;
                blue = bayer_data_i;
                green_sum = {1'b0, above_cur} + {1'b0, prev_pixel};
            end
            2'b10: begin
                red = above_cur;
                blue = prev_pixel;
                green_sum = {1'b0, above_prev} + {1'b0, bayer_data_i};
            end
            2'b01: begin
                red = prev_pixel;
                blue = above_cur;
                green_sum = {1'b0, above_prev} + {1'b0, bayer_data_i};
            end
            default: begin
                red = bayer_data_i;
                blue = above_prev;
                green_sum = {1'b0, above_cur} + {1'b0, prev_pixel};
            end
        endcase
    end

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count <= '0;
            y_count <= '0;
            line_valid_q <= 1'b0;
            pixel_o.line_valid <= 1'b0;
            pixel_o.frame_valid <= 1'b0;
        end else begin
            line_valid_q <= line_valid_i;
            x_count <= line_valid_i ? x_count + coord_t'(1) : '0;
            if (!frame_valid_i) begin
                y_count <= '0;
            end else if (line_valid_q && !line_valid_i) begin
                y_count <= y_count + coord_t'(1);
            end
            // First row and first column have no full neighbourhood
            pixel_o.line_valid <= line_valid_i && (x_count != '0) && (y_count != '0);
            pixel_o.frame_valid <= frame_valid_i;
        end
    end

    always_ff @(posedge clock_spi_in) begin
        if (line_valid_i) begin
            line_buffer[x_count] <= bayer_data_i;
            prev_pixel <= bayer_data_i;
            above_prev <= above_cur;
        end
        pixel_o.red <= red;
        pixel_o.green <= green_sum[$bits(raw_pixel_t):1];
        pixel_o.blue <= blue;
    end

    // Sensor lines only inside a frame
    assert property (@(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        line_valid_i |-> frame_valid_i);

endmodule

// File: hw/metering.sv
`timescale 1ns/1ps

module metering import camera_pkg::*; (
    input logic clock_spi_in,
    input logic mipi_byte_reset_n,
    pixel_if.sink pixel_i,
    output byte_t red_o,
    output byte_t green_o,
    output byte_t blue_o
);

    coord_t x_count;
    coord_t y_count;
    logic line_valid_q;
    logic frame_valid_q;
    logic in_window;

    logic [METER_SHIFT+$bits(byte_t)-1:0] red_sum;
    logic [METER_SHIFT+$bits(byte_t)-1:0] green_sum;
    logic [METER_SHIFT+$bits(byte_t)-1:0] blue_sum;

    assign in_window = (x_count >= METER_X_START) && (x_count < METER_X_END) &&
                       (y_count >= METER_Y_START) && (y_count < METER_Y_END);

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count <= '0;
            y_count <= '0;
            line_valid_q <= 1'b0;
            frame_valid_q <= 1'b0;
            red_sum <= '0;
            green_sum <= '0;
            blue_sum <= '0;
            red_o <= '0;
            green_o <= '0;
            blue_o <= '0;
        end else begin
            line_valid_q <= pixel_i.line_valid;
            frame_valid_q <= pixel_i.frame_valid;
            x_count <= pixel_i.line_valid ? x_count + coord_t'(1) : '0;
            if (!pixel_i.frame_valid) begin
                y_count <= '0;
            end else if (line_valid_q && !pixel_i.line_valid) begin
                y_count <= y_count + coord_t'(1);
            end

            if (frame_valid_q && !pixel_i.frame_valid) begin
                // Average is the window sum divided by the pixel count
                red_o <= red_sum[METER_SHIFT +: $bits(byte_t)];
                green_o <= green_sum[METER_SHIFT +: $bits(byte_t)];
                blue_o <= blue_sum[METER_SHIFT +: $bits(byte_t)];
                red_sum <= '0;
                green_sum <= '0;
                blue_sum <= '0;
            end else if (pixel_i.line_valid && in_window) begin
                // Upper 8 bits of each channel only
                red_sum <= red_sum + (METER_SHIFT + 8)'(pixel_i.red[9:2]);
                green_sum <= green_sum + (METER_SHIFT + 8)'(pixel_i.green[9:2]);
                blue_sum <= blue_sum + (METER_SHIFT + 8)'(pixel_i.blue[9:2]);
            end
        end
    end

endmodule

// File: hw/crop.sv
`timescale 1ns/1ps

module crop import camera_pkg::*; (
    input logic clock_spi_in,
    input logic mipi_byte_reset_n,
    pixel_if.sink pixel_i,
    pixel_if.source pixel_o
);

    coord_t x_count;
    coord_t y_count;
    logic line_valid_q;
    logic in_window;

    assign in_window = (x_count >= CROP_X_START) && (x_count < CROP_X_END) &&
                       (y_count >= CROP_Y_START) && (y_count < CROP_Y_END);

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count <= '0;
            y_count <= '0;
            line_valid_q <= 1'b0;
            pixel_o.line_valid <= 1'b0;
            pixel_o.frame_valid <= 1'b0;
        end else begin
            line_valid_q <= pixel_i.line_valid;
            x_count <= pixel_i.line_valid ? x_count + coord_t'(1) : '0;
            // Row counter restarts with every frame
            if (!pixel_i.frame_valid) begin
                y_count <= '0;
            end else if (line_valid_q && !pixel_i.line_valid) begin
                y_count <= y_count + coord_t'(1);
            end
            pixel_o.line_valid <= pixel_i.line_valid && in_window;
            pixel_o.frame_valid <= pixel_i.frame_valid;
        end
    end

    // Colour follows with the same delay as the valid levels
    always_ff @(posedge clock_spi_in) begin
        pixel_o.red <= pixel_i.red;
        pixel_o.green <= pixel_i.green;
        pixel_o.blue <= pixel_i.blue;
    end

endmodule

// File: hw/image_buffer.sv
`timescale 1ns/1ps

module image_buffer import camera_pkg::*; (
    input logic clock_spi_in,
    input buffer_addr_t address_i,
    input byte_t write_data_i,
    input logic write_enable_i,
    output byte_t read_data_o
);

    // One RGB332 byte per cropped pixel
    byte_t memory [CAPTURE_SIZE];

    always_ff @(posedge clock_spi_in) begin
        if (write_enable_i) begin
            memory[address_i[$clog2(CAPTURE_SIZE)-1:0]] <= write_data_i;
        end
        read_data_o <= memory[address_i[$clog2(CAPTURE_SIZE)-1:0]];
    end

    // Writes come from the crop window count, never past the frame size
    assert property (@(posedge clock_spi_in)
        write_enable_i |-> (address_i < buffer_addr_t'(CAPTURE_SIZE)));

endmodule

// File: hw/camera_command.sv
`timescale 1ns/1ps

module camera_command import camera_pkg::*; (
    input logic clock_spi_in,
    input logic mipi_byte_reset_n,
    input byte_t op_code_i,
    input logic op_code_valid_i,
    input logic operand_valid_i,
    input operand_count_t operand_count_i,
    input byte_t red_i,
    input byte_t green_i,
    input byte_t blue_i,
    pixel_if.sink cropped_i,
    input byte_t buffer_read_data_i,
    output buffer_addr_t buffer_address_o,
    output byte_t buffer_write_data_o,
    output logic buffer_write_enable_o,
    output byte_t response_o,
    output logic response_valid_o
);

    capture_state_t capture_state;
    buffer_addr_t bytes_read;
    buffer_addr_t bytes_remaining;
    buffer_addr_t write_count;
    buffer_addr_t write_address;
    logic operand_valid_q;
    logic frame_valid_q;
    logic capture_request;

    assign capture_request = op_code_valid_i && (op_code_i == OP_CAPTURE);
    assign bytes_remaining = buffer_addr_t'(CAPTURE_SIZE) - bytes_read;

    // Writes win the shared address, otherwise the read pointer
    assign buffer_address_o = buffer_write_enable_o ? write_address : bytes_read;

    // Host commands
    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            response_o <= '0;
            response_valid_o <= 1'b0;
            bytes_read <= '0;
            operand_valid_q <= 1'b0;
        end else begin
            operand_valid_q <= operand_valid_i;
            response_valid_o <= 1'b0;
            if (op_code_valid_i) begin
                case (op_code_i)
                    OP_CAPTURE: begin
                        response_o <= '0;
                        response_valid_o <= 1'b1;
                        if (capture_state == IDLE) begin
                            bytes_read <= '0;
                        end
                    end
                    OP_BYTES_AVAILABLE: begin
                        response_o <= (operand_count_i == '0) ? bytes_remaining[15:8]
                                                              : bytes_remaining[7:0];
                        response_valid_o <= 1'b1;
                    end
                    OP_READ_DATA: begin
                        response_o <= buffer_read_data_i;
                        response_valid_o <= 1'b1;
                        // One byte per operand strobe
                        if (operand_valid_i && !operand_valid_q) begin
                            bytes_read <= bytes_read + buffer_addr_t'(1);
                        end
                    end
                    OP_METERING: begin
                        case (operand_count_i)
                            8'd0: response_o <= red_i;
                            8'd1: response_o <= green_i;
                            default: response_o <= blue_i;
                        endcase
                        response_valid_o <= 1'b1;
                    end
                    default: response_valid_o <= 1'b0;
                endcase
            end
        end
    end

    // Capture FSM and write side
    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            capture_state <= IDLE;
            frame_valid_q <= 1'b0;
            write_count <= '0;
            buffer_write_enable_o <= 1'b0;
        end else begin
            frame_valid_q <= cropped_i.frame_valid;
            case (capture_state)
                IDLE: if (capture_request) capture_state <= ARMED;
                ARMED: if (cropped_i.frame_valid && !frame_valid_q) capture_state <= CAPTURING;
                default: if (!cropped_i.frame_valid && frame_valid_q) capture_state <= IDLE;
            endcase
            if (!cropped_i.frame_valid) begin
                write_count <= '0;
            end else if (cropped_i.line_valid) begin
                write_count <= write_count + buffer_addr_t'(1);
            end
            buffer_write_enable_o <= (capture_state == CAPTURING) && cropped_i.line_valid;
        end
    end

    always_ff @(posedge clock_spi_in) begin
        write_address <= write_count;
        // RGB332 packing
        buffer_write_data_o <= {cropped_i.red[9:7], cropped_i.green[9:7], cropped_i.blue[9:8]};
    end

    assert property (@(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        buffer_write_enable_o |-> (capture_state == CAPTURING));

endmodule

// File: hw/camera.sv
`timescale 1ns/1ps

module camera import camera_pkg::*; (
    input logic clock_spi_in,
    input logic mipi_byte_reset_n,
    input raw_pixel_t bayer_data_i,
    input logic line_valid_i,
    input logic frame_valid_i,
    input byte_t op_code_i,
    input logic op_code_valid_i,
    input logic operand_valid_i,
    input operand_count_t operand_count_i,
    output byte_t response_o,
    output logic response_valid_o
);

    pixel_if debayered ();
    pixel_if cropped ();

    byte_t red_metering;
    byte_t green_metering;
    byte_t blue_metering;
    buffer_addr_t buffer_address;
    byte_t buffer_write_data;
    byte_t buffer_read_data;
    logic buffer_write_enable;

    debayer u_debayer (
        .clock_spi_in(clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .bayer_data_i(bayer_data_i),
        .line_valid_i(line_valid_i),
        .frame_valid_i(frame_valid_i),
        .pixel_o(debayered.source)
    );

    // Metering sees the full debayered frame, not just the crop
    metering u_metering (
        .clock_spi_in(clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .pixel_i(debayered.sink),
        .red_o(red_metering),
        .green_o(green_metering),
        .blue_o(blue_metering)
    );

    crop u_crop (
        .clock_spi_in(clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .pixel_i(debayered.sink),
        .pixel_o(cropped.source)
    );

    camera_command u_camera_command (
        .clock_spi_in(clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .op_code_i(op_code_i),
        .op_code_valid_i(op_code_valid_i),
        .operand_valid_i(operand_valid_i),
        .operand_count_i(operand_count_i),
        .red_i(red_metering),
        .green_i(green_metering),
        .blue_i(blue_metering),
        .cropped_i(cropped.sink),
        .buffer_read_data_i(buffer_read_data),
        .buffer_address_o(buffer_address),
        .buffer_write_data_o(buffer_write_data),
        .buffer_write_enable_o(buffer_write_enable),
        .response_o(response_o),
        .response_valid_o(response_valid_o)
    );

    image_buffer u_image_buffer (
        .clock_spi_in(clock_spi_in),
        .address_i(buffer_address),
        .write_data_i(buffer_write_data),
        .write_enable_i(buffer_write_enable),
        .read_data_o(buffer_read_data)
    );

endmodule

// File: sim/camera_tb.sv
`timescale 1ns/1ps

module camera_tb import camera_pkg::*; ();

    localparam int CLOCK_PERIOD = 20;
    localparam int RESET_CYCLES = 10;
    localparam int DRIVE_DELAY = 1;
    localparam int LINE_GAP = 4;
    localparam int FRAME_PORCH = 8;
    localparam int RESPONSE_TIMEOUT = 10;
    localparam int UNKNOWN_WINDOW = 5;
    localparam int READ_LATENCY = 3;
    localparam int CROP_WIDTH = int'(CROP_X_END) - int'(CROP_X_START);
    localparam int unsigned RANDOM_SEED = 32'he4e6_9016;

    logic clock_spi_in;
    logic mipi_byte_reset_n;
    raw_pixel_t bayer_data;
    logic line_valid;
    logic frame_valid;
    byte_t op_code;
    logic op_code_valid;
    logic operand_valid;
    operand_count_t operand_count;
    byte_t response;
    logic response_valid;

    // Second raw frame serves the mid-frame capture
    raw_pixel_t frames [2][SENSOR_HEIGHT][SENSOR_WIDTH];
    int expected_capture [CAPTURE_SIZE];
    int error_count;
    int check_count;

    camera u_camera (
        .clock_spi_in(clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .bayer_data_i(bayer_data),
        .line_valid_i(line_valid),
        .frame_valid_i(frame_valid),
        .op_code_i(op_code),
        .op_code_valid_i(op_code_valid),
        .operand_valid_i(operand_valid),
        .operand_count_i(operand_count),
        .response_o(response),
        .response_valid_o(response_valid)
    );

    initial begin
        clock_spi_in = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock_spi_in = ~clock_spi_in;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic abort_on_timeout(input string reason);
        $display("Timed out at %0t while waiting for %s", $time, reason);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d mismatches", name, error_count - errors_before);
        end
    endtask

    // Inputs change a little after the rising edge
    task automatic next_drive_slot();
        @(posedge clock_spi_in);
        #DRIVE_DELAY;
    endtask

    task automatic fill_frame(input int slot);
        int row;
        int column;
        for (row = 0; row < SENSOR_HEIGHT; row++) begin
            for (column = 0; column < SENSOR_WIDTH; column++) begin
                frames[slot][row][column] = raw_pixel_t'($urandom);
            end
        end
    endtask

    task automatic send_frame(input int slot);
        int row;
        int column;
        int gap;
        next_drive_slot();
        frame_valid = 1'b1;
        next_drive_slot();
        for (row = 0; row < SENSOR_HEIGHT; row++) begin
            for (column = 0; column < SENSOR_WIDTH; column++) begin
                line_valid = 1'b1;
                bayer_data = frames[slot][row][column];
                next_drive_slot();
            end
            for (gap = 0; gap < LINE_GAP; gap++) begin
                line_valid = 1'b0;
                bayer_data = '0;
                next_drive_slot();
            end
        end
        frame_valid = 1'b0;
        // Vertical blanking, long enough for capture and metering to settle
        repeat (FRAME_PORCH) next_drive_slot();
    endtask

    // Reference debayer of the 2x2 block that ends at raw (x, y)
    function automatic void debayer_block(input int slot, input int x, input int y,
                                          output int red, output int green, output int blue);
        int dx;
        int dy;
        int row;
        int column;
        int sample;
        int green_sum;
        red = 0;
        blue = 0;
        green_sum = 0;
        for (dy = 0; dy < 2; dy++) begin
            for (dx = 0; dx < 2; dx++) begin
                row = y - 1 + dy;
                column = x - 1 + dx;
                sample = int'(frames[slot][row][column]);
                // RGGB has red on even row and column and blue on odd row and column
                if (row % 2 == 0 && column % 2 == 0) begin
                    red = sample;
                end else if (row % 2 == 1 && column % 2 == 1) begin
                    blue = sample;
                end else begin
                    green_sum += sample;
                end
            end
        end
        green = green_sum / 2;
    endfunction

    function automatic int pack_rgb332(input int red, input int green, input int blue);
        return (((red >> 7) & 7) << 5) | (((green >> 7) & 7) << 2) | ((blue >> 8) & 3);
    endfunction

    task automatic build_expected_capture(input int slot);
        int index;
        int x;
        int y;
        int red;
        int green;
        int blue;
        for (index = 0; index < CAPTURE_SIZE; index++) begin
            y = int'(CROP_Y_START) + index / CROP_WIDTH;
            x = int'(CROP_X_START) + index % CROP_WIDTH;
            // Debayered column 0 and row 0 come from raw column 1 and row 1
            debayer_block(slot, x + 1, y + 1, red, green, blue);
            expected_capture[index] = pack_rgb332(red, green, blue);
        end
    endtask

    task automatic meter_frame(input int slot, output int red_avg, output int green_avg,
                               output int blue_avg);
        int x;
        int y;
        int red;
        int green;
        int blue;
        int red_sum;
        int green_sum;
        int blue_sum;
        red_sum = 0;
        green_sum = 0;
        blue_sum = 0;
        for (y = int'(METER_Y_START); y < int'(METER_Y_END); y++) begin
            for (x = int'(METER_X_START); x < int'(METER_X_END); x++) begin
                debayer_block(slot, x + 1, y + 1, red, green, blue);
                red_sum += red >> 2;
                green_sum += green >> 2;
                blue_sum += blue >> 2;
            end
        end
        red_avg = red_sum >> METER_SHIFT;
        green_avg = green_sum >> METER_SHIFT;
        blue_avg = blue_sum >> METER_SHIFT;
    endtask

    task automatic wait_response_low();
        int waited;
        waited = 0;
        @(negedge clock_spi_in);
        while (response_valid !== 1'b0 && waited < RESPONSE_TIMEOUT) begin
            @(negedge clock_spi_in);
            waited++;
        end
        if (response_valid !== 1'b0) begin
            abort_on_timeout("response valid to drop");
        end
    endtask

    task automatic issue_command(input byte_t op, input int operand, output byte_t value);
        int waited;
        next_drive_slot();
        op_code = op;
        operand_count = operand_count_t'(operand);
        op_code_valid = 1'b1;
        waited = 0;
        @(negedge clock_spi_in);
        while (response_valid !== 1'b1 && waited < RESPONSE_TIMEOUT) begin
            @(negedge clock_spi_in);
            waited++;
        end
        if (response_valid !== 1'b1) begin
            abort_on_timeout("a command response");
        end
        value = response;
        next_drive_slot();
        op_code_valid = 1'b0;
        wait_response_low();
    endtask

    // Reads bytes in raster order with one operand strobe per byte
    task automatic read_bytes(input int count, input string what);
        int index;
        next_drive_slot();
        op_code = OP_READ_DATA;
        operand_count = '0;
        op_code_valid = 1'b1;
        repeat (READ_LATENCY) @(posedge clock_spi_in);
        for (index = 0; index < count; index++) begin
            @(negedge clock_spi_in);
            check_value(32'(response), 32'(expected_capture[index]),
                        $sformatf("%s byte %0d", what, index));
            next_drive_slot();
            operand_valid = 1'b1;
            next_drive_slot();
            operand_valid = 1'b0;
            // Pointer moved on the last edge and data follows within three more
            repeat (READ_LATENCY) @(posedge clock_spi_in);
        end
        next_drive_slot();
        op_code_valid = 1'b0;
        wait_response_low();
    endtask

    task automatic after_reset_idle();
        int errors_before;
        int cycle;
        byte_t value;
        errors_before = error_count;
        for (cycle = 0; cycle < RESET_CYCLES; cycle++) begin
            @(negedge clock_spi_in);
            check_value(32'(response_valid), 0, "response valid while idle");
        end
        issue_command(OP_BYTES_AVAILABLE, 0, value);
        check_value(32'(value), (CAPTURE_SIZE >> 8) & 255, "bytes available high");
        issue_command(OP_BYTES_AVAILABLE, 1, value);
        check_value(32'(value), CAPTURE_SIZE & 255, "bytes available low");
        report_test("after reset", errors_before);
    endtask

    task automatic metering_averages();
        int errors_before;
        int red;
        int green;
        int blue;
        byte_t value;
        errors_before = error_count;
        fill_frame(0);
        send_frame(0);
        meter_frame(0, red, green, blue);
        issue_command(OP_METERING, 0, value);
        check_value(32'(value), red, "metering red");
        issue_command(OP_METERING, 1, value);
        check_value(32'(value), green, "metering green");
        issue_command(OP_METERING, 2, value);
        check_value(32'(value), blue, "metering blue");
        report_test("metering", errors_before);
    endtask

    task automatic capture_and_read();
        int errors_before;
        byte_t value;
        errors_before = error_count;
        fill_frame(0);
        issue_command(OP_CAPTURE, 0, value);
        send_frame(0);
        build_expected_capture(0);
        read_bytes(CAPTURE_SIZE, "readback");
        report_test("capture readback", errors_before);
    endtask

    task automatic bytes_countdown();
        int errors_before;
        byte_t value;
        errors_before = error_count;
        fill_frame(0);
        issue_command(OP_CAPTURE, 0, value);
        send_frame(0);
        build_expected_capture(0);
        read_bytes(100, "partial readback");
        issue_command(OP_BYTES_AVAILABLE, 0, value);
        check_value(32'(value), ((CAPTURE_SIZE - 100) >> 8) & 255, "remaining high");
        issue_command(OP_BYTES_AVAILABLE, 1, value);
        check_value(32'(value), (CAPTURE_SIZE - 100) & 255, "remaining low");
        report_test("bytes countdown", errors_before);
    endtask

    task automatic mid_frame_capture();
        int errors_before;
        byte_t value;
        errors_before = error_count;
        fill_frame(0);
        fill_frame(1);
        fork
            send_frame(0);
            begin
                // Request lands about ten lines into the first frame
                repeat (10 * (SENSOR_WIDTH + LINE_GAP)) @(posedge clock_spi_in);
                issue_command(OP_CAPTURE, 0, value);
            end
        join
        send_frame(1);
        build_expected_capture(1);
        read_bytes(64, "mid-frame capture");
        report_test("mid-frame capture", errors_before);
    endtask

    task automatic unknown_op_ignored();
        int errors_before;
        int cycle;
        errors_before = error_count;
        next_drive_slot();
        op_code = 8'h30;
        operand_count = '0;
        op_code_valid = 1'b1;
        next_drive_slot();
        op_code_valid = 1'b0;
        for (cycle = 0; cycle < UNKNOWN_WINDOW; cycle++) begin
            @(negedge clock_spi_in);
            check_value(32'(response_valid), 0, "response valid for unknown op code");
        end
        report_test("unknown op code", errors_before);
    endtask

    initial begin
        void'($urandom(RANDOM_SEED));
        mipi_byte_reset_n = 1'b0;
        bayer_data = '0;
        line_valid = 1'b0;
        frame_valid = 1'b0;
        op_code = '0;
        op_code_valid = 1'b0;
        operand_valid = 1'b0;
        operand_count = '0;
        error_count = 0;
        check_count = 0;
        repeat (RESET_CYCLES) @(posedge clock_spi_in);
        #DRIVE_DELAY;
        mipi_byte_reset_n = 1'b1;

        after_reset_idle();
        metering_averages();
        capture_and_read();
        bytes_countdown();
        mid_frame_capture();
        unknown_op_ignored();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
hw/camera_pkg.sv
hw/pixel_if.sv
hw/debayer.sv
hw/metering.sv
hw/crop.sv
hw/image_buffer.sv
hw/camera_command.sv
hw/camera.sv
sim/camera_tb.sv

// File: Makefile
TOP = camera_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal --top-module $(TOP) -f list.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
